// ==== design/cpu_pkg.sv ====
package cpu_pkg;

    // datapath and address width
    localparam int unsigned xlen = 32;

    // first fetch after reset, in kseg1
    localparam logic [xlen-1:0] reset_pc = 32'hBFC0_0000;

    // exception entry points while BEV is set
    localparam logic [xlen-1:0] refill_vector  = 32'hBFC0_0200;
    localparam logic [xlen-1:0] general_vector = 32'hBFC0_0380;

    // TLB entry fields
    localparam int unsigned vpn2_width = 19;
    localparam int unsigned pfn_width  = 20;

    // 4 KiB pages
    localparam int unsigned page_offset_width = 12;

    // top three address bits of the unmapped kernel segments
    localparam logic [2:0] kseg0_top = 3'b100;
    localparam logic [2:0] kseg1_top = 3'b101;

endpackage

// ==== design/cp0_pkg.sv ====
package cp0_pkg;

    // width of the Cause.ExcCode field
    localparam int unsigned exccode_width = 5;

    // address error on load or instruction fetch
    localparam logic [exccode_width-1:0] exc_adel = 5'd4;

    // TLB miss or invalid entry on load or instruction fetch
    localparam logic [exccode_width-1:0] exc_tlbl = 5'd2;

endpackage

// ==== design/addr_trans.sv ====
`timescale 1ns/1ps

module addr_trans import cpu_pkg::*; #(
    parameter bit tlb_enable = 1'b1
) (
    input  logic [xlen-1:0]       virt_addr,
    input  logic [pfn_width-1:0]  tlb_pfn,
    output logic [xlen-1:0]       phys_addr,
    output logic                  mapped,
    output logic [vpn2_width-1:0] tlb_vpn2,
    output logic                  tlb_odd
);

    logic unmapped_seg;

    // kseg0 and kseg1 bypass the TLB
    assign unmapped_seg = (virt_addr[xlen-1 -: 3] == kseg0_top) ||
                          (virt_addr[xlen-1 -: 3] == kseg1_top);

    assign mapped = tlb_enable && !unmapped_seg;

    // lookup key goes out every cycle, only used when mapped
    assign tlb_vpn2 = virt_addr[xlen-1 -: vpn2_width];
    assign tlb_odd  = virt_addr[page_offset_width];

    always_comb begin
        if (mapped) begin
            phys_addr = {tlb_pfn, virt_addr[page_offset_width-1:0]};
        end else begin
            // fixed mapping strips the segment bits
            phys_addr = {3'b000, virt_addr[xlen-4:0]};
        end
    end

endmodule

// ==== design/fault_priority.sv ====
`timescale 1ns/1ps

module fault_priority import cp0_pkg::*; #(
    parameter int num_faults = 2
) (
    input  logic [num_faults-1:0]               faults,
    input  logic [num_faults*exccode_width-1:0] codes,
    output logic                                fault,
    output logic [exccode_width-1:0]            exccode
);

    assign fault = |faults;

    // walk from the lowest priority up so index 0 ends up on top
    always_comb begin
        exccode = '0;
        for (int i = num_faults - 1; i >= 0; i--) begin
            if (faults[i]) begin
                exccode = codes[i*exccode_width +: exccode_width];
            end
        end
    end

endmodule

// ==== design/pc_select.sv ====
`timescale 1ns/1ps

module pc_select import cpu_pkg::*, cp0_pkg::*; #(
    parameter bit tlb_enable = 1'b1
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     redirect,

    input  logic                     exc_now,
    input  logic                     exc_refill,
    input  logic                     eret_now,
    input  logic [xlen-1:0]          epc,
    input  logic                     refetch_now,
    input  logic [xlen-1:0]          refetch_pc,
    input  logic                     branch_now,
    input  logic [xlen-1:0]          branch_target,

    input  logic                     tlb_found,
    input  logic                     tlb_valid,
    input  logic [pfn_width-1:0]     tlb_pfn,
    input  logic                     sram_addr_ok,
    input  logic                     slot_free,

    output logic                     sram_req,
    output logic [xlen-1:0]          sram_addr,
    output logic [vpn2_width-1:0]    tlb_vpn2,
    output logic                     tlb_odd,

    output logic                     issue,
    output logic [xlen-1:0]          issue_pc,
    output logic                     issue_fault,
    output logic [exccode_width-1:0] issue_exccode,
    output logic                     issue_refill
);

    logic [xlen-1:0] pc;
    logic [xlen-1:0] req_addr;
    logic            running;
    logic            can_go;
    logic            mapped;
    logic            addr_error;
    logic            tlb_error;

    // address requested this cycle, redirects take precedence over pc
    always_comb begin
        if (exc_now) begin
            req_addr = exc_refill ? refill_vector : general_vector;
        end else if (eret_now) begin
            req_addr = epc;
        end else if (refetch_now) begin
            req_addr = refetch_pc;
        end else if (branch_now) begin
            req_addr = branch_target;
        end else begin
            req_addr = pc;
        end
    end

    addr_trans #(
        .tlb_enable(tlb_enable)
    ) addr_trans0 (
        .virt_addr(req_addr),
        .tlb_pfn  (tlb_pfn),
        .phys_addr(sram_addr),
        .mapped   (mapped),
        .tlb_vpn2 (tlb_vpn2),
        .tlb_odd  (tlb_odd)
    );

    assign addr_error = (req_addr[1:0] != 2'b00);
    assign tlb_error  = mapped && !(tlb_found && tlb_valid);

    // AdEL sits at index 0 and wins over TLBL
    fault_priority #(
        .num_faults(2)
    ) fault_priority0 (
        .faults ({tlb_error, addr_error}),
        .codes  ({exc_tlbl, exc_adel}),
        .fault  (issue_fault),
        .exccode(issue_exccode)
    );

    // a plain miss needs the refill handler, an invalid entry does not
    assign issue_refill = !addr_error && mapped && !tlb_found;

    // hold off for one cycle after reset drops
    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    assign can_go = running && slot_free;

    // faulting fetches never reach the bus
    assign sram_req = can_go && !issue_fault;
    assign issue    = (sram_req && sram_addr_ok) || (can_go && issue_fault);
    assign issue_pc = req_addr;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (issue) begin
            pc <= req_addr + xlen'(4);
        end else if (redirect) begin
            // not accepted yet, retry the new target next cycle
            pc <= req_addr;
        end
    end

endmodule

// ==== design/fetch_wait.sv ====
`timescale 1ns/1ps

module fetch_wait import cpu_pkg::*, cp0_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     redirect,

    input  logic                     issue,
    input  logic [xlen-1:0]          issue_pc,
    input  logic                     issue_fault,
    input  logic [exccode_width-1:0] issue_exccode,
    input  logic                     issue_refill,

    input  logic                     sram_data_ok,
    input  logic [xlen-1:0]          sram_rdata,
    input  logic                     inst_ready,

    output logic                     slot_free,
    output logic                     inst_valid,
    output logic [xlen-1:0]          inst_pc,
    output logic [xlen-1:0]          inst_word,
    output logic                     inst_fault,
    output logic [exccode_width-1:0] inst_exccode,
    output logic                     inst_refill
);

    // pending slot, pend_got means the word (or a fault) is already here
    logic                     pend_valid;
    logic                     pend_got;
    logic [xlen-1:0]          pend_pc;
    logic [xlen-1:0]          pend_word;
    logic                     pend_fault;
    logic [exccode_width-1:0] pend_exccode;
    logic                     pend_refill;

    // one stale response still to come from a cancelled stream
    logic                     discard;

    logic data_in;
    logic out_open;
    logic pend_leaves;
    logic pend_waiting;
    logic disc_left;
    logic direct_fault;

    assign data_in      = sram_data_ok && !discard;
    assign out_open     = !inst_valid || inst_ready;
    assign pend_leaves  = pend_valid && (pend_got || data_in) && out_open;
    assign pend_waiting = pend_valid && !pend_got && !data_in;
    assign disc_left    = discard && !sram_data_ok;

    // never let a live request sit behind a stale one, so one flag is enough
    assign slot_free = redirect ? !(disc_left || pend_waiting)
                                : !disc_left && (!pend_valid || pend_leaves);

    // faults skip the pending slot when nothing is ahead of them
    assign direct_fault = issue && issue_fault && (redirect || (!pend_valid && out_open));

    always_ff @(posedge clk) begin
        if (reset) begin
            discard <= 1'b0;
        end else if (redirect && pend_waiting) begin
            discard <= 1'b1;
        end else if (sram_data_ok) begin
            discard <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid <= 1'b0;
            pend_got   <= 1'b0;
        end else if (issue && !direct_fault) begin
            pend_valid <= 1'b1;
            pend_got   <= issue_fault;
        end else if (redirect || pend_leaves) begin
            pend_valid <= 1'b0;
            pend_got   <= 1'b0;
        end else if (data_in) begin
            pend_got <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (issue && !direct_fault) begin
            pend_pc      <= issue_pc;
            pend_word    <= '0;
            pend_fault   <= issue_fault;
            pend_exccode <= issue_exccode;
            pend_refill  <= issue_refill;
        end else if (data_in && !pend_got) begin
            pend_word <= sram_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            inst_valid <= 1'b0;
        end else if (direct_fault || (pend_leaves && !redirect)) begin
            inst_valid <= 1'b1;
        end else if (redirect || inst_ready) begin
            inst_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (direct_fault) begin
            inst_pc      <= issue_pc;
            inst_word    <= '0;
            inst_fault   <= 1'b1;
            inst_exccode <= issue_exccode;
            inst_refill  <= issue_refill;
        end else if (pend_leaves && !redirect) begin
            inst_pc      <= pend_pc;
            // bypass the word when it arrives in the same cycle
            inst_word    <= pend_got ? pend_word : sram_rdata;
            inst_fault   <= pend_fault;
            inst_exccode <= pend_exccode;
            inst_refill  <= pend_refill;
        end
    end

endmodule

// ==== design/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top import cpu_pkg::*, cp0_pkg::*; #(
    parameter bit tlb_enable = 1'b1
) (
    input  logic                     clk,
    input  logic                     reset,

    // instruction SRAM
    output logic                     sram_req,
    output logic [xlen-1:0]          sram_addr,
    input  logic                     sram_addr_ok,
    input  logic                     sram_data_ok,
    input  logic [xlen-1:0]          sram_rdata,

    // TLB lookup, answered in the same cycle
    output logic [vpn2_width-1:0]    tlb_vpn2,
    output logic                     tlb_odd,
    input  logic [pfn_width-1:0]     tlb_pfn,
    input  logic                     tlb_found,
    input  logic                     tlb_valid,

    // redirect pulses
    input  logic                     exc_now,
    input  logic                     exc_refill,
    input  logic                     eret_now,
    input  logic [xlen-1:0]          epc,
    input  logic                     refetch_now,
    input  logic [xlen-1:0]          refetch_pc,
    input  logic                     branch_now,
    input  logic [xlen-1:0]          branch_target,

    // toward decode
    output logic                     inst_valid,
    input  logic                     inst_ready,
    output logic [xlen-1:0]          inst_pc,
    output logic [xlen-1:0]          inst_word,
    output logic                     inst_fault,
    output logic [exccode_width-1:0] inst_exccode,
    output logic                     inst_refill
);

    logic                     redirect;
    logic                     slot_free;
    logic                     issue;
    logic [xlen-1:0]          issue_pc;
    logic                     issue_fault;
    logic [exccode_width-1:0] issue_exccode;
    logic                     issue_refill;

    assign redirect = exc_now || eret_now || refetch_now || branch_now;

    pc_select #(
        .tlb_enable(tlb_enable)
    ) pc_select0 (
        .clk          (clk),
        .reset        (reset),
        .redirect     (redirect),
        .exc_now      (exc_now),
        .exc_refill   (exc_refill),
        .eret_now     (eret_now),
        .epc          (epc),
        .refetch_now  (refetch_now),
        .refetch_pc   (refetch_pc),
        .branch_now   (branch_now),
        .branch_target(branch_target),
        .tlb_found    (tlb_found),
        .tlb_valid    (tlb_valid),
        .tlb_pfn      (tlb_pfn),
        .sram_addr_ok (sram_addr_ok),
        .slot_free    (slot_free),
        .sram_req     (sram_req),
        .sram_addr    (sram_addr),
        .tlb_vpn2     (tlb_vpn2),
        .tlb_odd      (tlb_odd),
        .issue        (issue),
        .issue_pc     (issue_pc),
        .issue_fault  (issue_fault),
        .issue_exccode(issue_exccode),
        .issue_refill (issue_refill)
    );

    fetch_wait fetch_wait0 (
        .clk          (clk),
        .reset        (reset),
        .redirect     (redirect),
        .issue        (issue),
        .issue_pc     (issue_pc),
        .issue_fault  (issue_fault),
        .issue_exccode(issue_exccode),
        .issue_refill (issue_refill),
        .sram_data_ok (sram_data_ok),
        .sram_rdata   (sram_rdata),
        .inst_ready   (inst_ready),
        .slot_free    (slot_free),
        .inst_valid   (inst_valid),
        .inst_pc      (inst_pc),
        .inst_word    (inst_word),
        .inst_fault   (inst_fault),
        .inst_exccode (inst_exccode),
        .inst_refill  (inst_refill)
    );

endmodule

// ==== tests/fetch_properties.sv ====
`timescale 1ns/1ps

module fetch_properties import cpu_pkg::*, cp0_pkg::*; #(
    parameter bit tlb_enable = 1'b1
) (
    input logic                     clk,
    input logic                     reset,
    input logic                     sram_req,
    input logic [xlen-1:0]          sram_addr,
    input logic                     exc_now,
    input logic                     exc_refill,
    input logic                     eret_now,
    input logic [xlen-1:0]          epc,
    input logic                     refetch_now,
    input logic [xlen-1:0]          refetch_pc,
    input logic                     branch_now,
    input logic [xlen-1:0]          branch_target,
    input logic                     inst_valid,
    input logic                     inst_ready,
    input logic [xlen-1:0]          inst_pc,
    input logic [xlen-1:0]          inst_word,
    input logic                     inst_fault,
    input logic [exccode_width-1:0] inst_exccode,
    input logic                     inst_refill
);

    int unsigned     errors = 0;
    logic            any_redirect;
    logic [xlen-1:0] target;
    logic [xlen-1:0] expect_pc;

    // only kseg0 and kseg1 bypass the TLB
    function automatic logic is_mapped(input logic [xlen-1:0] va);
        return tlb_enable && (va[xlen-1 -: 2] != 2'b10);
    endfunction

    // the TLB model misses whenever bit 0 of VPN2 is set
    function automatic logic tlb_miss(input logic [xlen-1:0] va);
        return is_mapped(va) && va[xlen-vpn2_width];
    endfunction

    // a hit returns {vpn2, odd} as the frame, so mapped pages land on themselves
    function automatic logic [xlen-1:0] expect_word(input logic [xlen-1:0] va);
        if (is_mapped(va)) begin
            return ~va;
        end
        return ~{3'b000, va[xlen-4:0]};
    endfunction

    assign any_redirect = exc_now || eret_now || refetch_now || branch_now;

    always_comb begin
        if (exc_now) begin
            target = exc_refill ? refill_vector : general_vector;
        end else if (eret_now) begin
            target = epc;
        end else if (refetch_now) begin
            target = refetch_pc;
        end else begin
            target = branch_target;
        end
    end

    // next pc that decode should see
    always_ff @(posedge clk) begin
        if (reset) begin
            expect_pc <= reset_pc;
        end else if (any_redirect) begin
            expect_pc <= target;
        end else if (inst_valid && inst_ready) begin
            expect_pc <= inst_pc + 32'd4;
        end
    end

    after_reset_idle: assert property (@(posedge clk) $fell(reset) |-> !sram_req && !inst_valid)
        else begin
            $error("request or valid raised in the first cycle after reset");
            errors++;
        end

    in_order_pc: assert property (@(posedge clk) disable iff (reset)
        inst_valid |-> inst_pc == expect_pc)
        else begin
            $error("inst_pc %h, expected %h", inst_pc, expect_pc);
            errors++;
        end

    stable_when_stalled: assert property (@(posedge clk) disable iff (reset)
        inst_valid && !inst_ready && !any_redirect
        |=> inst_valid && $stable({inst_pc, inst_word, inst_fault, inst_exccode, inst_refill}))
        else begin
            $error("output item changed while decode stalled");
            errors++;
        end

    aligned_request: assert property (@(posedge clk) disable iff (reset)
        sram_req |-> sram_addr[1:0] == 2'b00)
        else begin
            $error("request raised for misaligned address %h", sram_addr);
            errors++;
        end

    adel_reported: assert property (@(posedge clk) disable iff (reset)
        inst_valid && inst_pc[1:0] != 2'b00
        |-> inst_fault && inst_exccode == exc_adel && inst_word == '0)
        else begin
            $error("misaligned pc %h not reported as AdEL", inst_pc);
            errors++;
        end

    tlbl_reported: assert property (@(posedge clk) disable iff (reset)
        inst_valid && inst_pc[1:0] == 2'b00 && tlb_miss(inst_pc)
        |-> inst_fault && inst_exccode == exc_tlbl && inst_refill)
        else begin
            $error("TLB miss at pc %h not reported as TLBL refill", inst_pc);
            errors++;
        end

    clean_fetch: assert property (@(posedge clk) disable iff (reset)
        inst_valid && inst_pc[1:0] == 2'b00 && !tlb_miss(inst_pc)
        |-> !inst_fault && inst_word == expect_word(inst_pc))
        else begin
            $error("pc %h delivered word %h, expected %h", inst_pc, inst_word,
                   expect_word(inst_pc));
            errors++;
        end

endmodule

bind fetch_top fetch_properties #(
    .tlb_enable(tlb_enable)
) props0 (.*);

// ==== tests/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb import cpu_pkg::*, cp0_pkg::*; ();

    localparam int timeout_cycles = 300;

    logic                     clk           = 1'b0;
    logic                     reset         = 1'b1;
    logic                     sram_req;
    logic [xlen-1:0]          sram_addr;
    logic                     sram_addr_ok  = 1'b0;
    logic                     sram_data_ok  = 1'b0;
    logic [xlen-1:0]          sram_rdata    = '0;
    logic [vpn2_width-1:0]    tlb_vpn2;
    logic                     tlb_odd;
    logic [pfn_width-1:0]     tlb_pfn;
    logic                     tlb_found;
    logic                     tlb_valid;
    logic                     exc_now       = 1'b0;
    logic                     exc_refill    = 1'b0;
    logic                     eret_now      = 1'b0;
    logic [xlen-1:0]          epc           = '0;
    logic                     refetch_now   = 1'b0;
    logic [xlen-1:0]          refetch_pc    = '0;
    logic                     branch_now    = 1'b0;
    logic [xlen-1:0]          branch_target = '0;
    logic                     inst_valid;
    logic                     inst_ready    = 1'b0;
    logic [xlen-1:0]          inst_pc;
    logic [xlen-1:0]          inst_word;
    logic                     inst_fault;
    logic [exccode_width-1:0] inst_exccode;
    logic                     inst_refill;

    logic [15:0]     lfsr = 16'd33138;
    logic [xlen-1:0] mem_q[$];
    int              gap = 0;
    int              delivered = 0;

    fetch_top #(
        .tlb_enable(1'b1)
    ) dut0 (.*);

    always #4 clk = ~clk;

    // galois lfsr with taps 16 14 13 11
    function automatic int rand_bits(input int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return val;
    endfunction

    // even VPN2 hits a valid entry and odd VPN2 misses
    always_comb begin
        tlb_found = !tlb_vpn2[0];
        tlb_valid = !tlb_vpn2[0];
        tlb_pfn   = tlb_found ? {tlb_vpn2, tlb_odd} : '0;
    end

    // SRAM returns data in order with 0 to 3 idle cycles between words
    always @(posedge clk) begin
        if (!reset && sram_data_ok) begin
            void'(mem_q.pop_front());
        end
        if (!reset && sram_req && sram_addr_ok) begin
            mem_q.push_back(sram_addr);
        end
        #1;
        sram_addr_ok = (rand_bits(1) == 1);
        inst_ready   = (rand_bits(1) == 1);
        sram_data_ok = 1'b0;
        if (mem_q.size() > 0) begin
            if (gap == 0) begin
                sram_data_ok = 1'b1;
                sram_rdata   = ~mem_q[0];
                gap          = rand_bits(2);
            end else begin
                gap--;
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && inst_valid && inst_ready) begin
            delivered++;
        end
    end

    always @(negedge clk) begin
        if (dut0.props0.errors != 0) begin
            $display("MISMATCH at %0t: %0d assertion failure(s) on the fetch outputs",
                     $time, dut0.props0.errors);
            $display("Test failed");
            $fatal(1, "stopped at first assertion failure");
        end
    end

    task automatic wait_items(input int n);
        int start;
        int cycles;
        start  = delivered;
        cycles = 0;
        while (delivered < start + n) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > timeout_cycles) begin
                $display("timeout at %0t: only %0d of %0d items reached decode",
                         $time, delivered - start, n);
                $display("Test failed");
                $fatal(1, "fetch made no progress");
            end
        end
    endtask

    // redirect inputs are single-cycle pulses
    task automatic end_pulse();
        @(posedge clk);
        #1;
        exc_now     = 1'b0;
        exc_refill  = 1'b0;
        eret_now    = 1'b0;
        refetch_now = 1'b0;
        branch_now  = 1'b0;
    endtask

    initial begin
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        wait_items(6);
        // kuseg run through the TLB
        branch_target = 32'h0040_0000;
        branch_now    = 1'b1;
        end_pulse();
        wait_items(6);
        refetch_pc  = 32'hBFC0_1000;
        refetch_now = 1'b1;
        end_pulse();
        wait_items(6);
        // odd VPN2 so every fetch misses
        epc      = 32'h0040_2000;
        eret_now = 1'b1;
        end_pulse();
        wait_items(3);
        exc_refill = 1'b1;
        exc_now    = 1'b1;
        end_pulse();
        wait_items(4);
        exc_now = 1'b1;
        end_pulse();
        wait_items(4);
        refetch_pc  = 32'hBFC0_2002;
        refetch_now = 1'b1;
        end_pulse();
        wait_items(3);
        // kseg0 run
        branch_target = 32'h8000_1000;
        branch_now    = 1'b1;
        end_pulse();
        wait_items(6);
        repeat (4) @(posedge clk);
        #1;
        if (dut0.props0.errors != 0) begin
            $display("MISMATCH at %0t: assertion failures were recorded", $time);
            $display("Test failed");
            $fatal(1, "assertion failures");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

// ==== list.f ====
design/cpu_pkg.sv
design/cp0_pkg.sv
design/addr_trans.sv
design/fault_priority.sv
design/pc_select.sv
design/fetch_wait.sv
design/fetch_top.sv
tests/fetch_properties.sv
tests/fetch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fetch_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Test completed successfully

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
